// File: sim.f
src/io_pkg.sv
src/io_dev_if.sv
src/io_decode.sv
src/scratch_ram.sv
src/sema_ram.sv
src/board_regs.sv
src/io_subsys.sv
test/io_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the io subsystem testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f sim.f \
	--top-module io_subsys_tb -o io_subsys_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/io_subsys_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
echo "pass message not found"
exit 1

// File: test/io_subsys_tb.sv
`timescale 1ns/100ps
`default_nettype none

module io_subsys_tb;

	localparam logic [31:0] GEN_RESET = 32'h0000_0001;	// generator value after reset
	localparam logic [31:0] GALOIS_TAPS = 32'h8020_0003;	// x^32+x^22+x^2+x+1
	localparam int ACK_EDGE = 4;	// ack set on the third edge, seen here one edge later
	localparam int ACK_TIMEOUT = 20;
	localparam logic [31:0] RAND_ADR = 32'hFD0F_FD00;

	logic node_clk;
	logic rst;
	logic cyc_i;
	logic stb_i;
	logic we_i;
	logic [3:0] sel_i;
	logic [31:0] adr_i;
	logic [31:0] dat_i;
	logic [31:0] dat_o;
	logic ack_o;
	logic [7:0] led_o;

	integer seed = 32'h9dcd9135;
	int errors = 0;
	int timeouts = 0;
	int checks = 0;

	// reference model state
	logic [31:0] shadow_scr [4096];
	logic [7:0] shadow_sema [256];
	logic [7:0] shadow_led;
	logic [31:0] shadow_lfsr;
	logic [31:0] exp_q [$];	// expected dat_o per access in flight

	io_subsys io_subsys_i (
		.node_clk(node_clk),
		.rst(rst),
		.cyc_i(cyc_i),
		.stb_i(stb_i),
		.we_i(we_i),
		.sel_i(sel_i),
		.adr_i(adr_i),
		.dat_i(dat_i),
		.dat_o(dat_o),
		.ack_o(ack_o),
		.led_o(led_o)
	);

	initial begin
		node_clk = 1'b0;
		forever #5 node_clk = ~node_clk;
	end

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] v);
		return (v >> 1) ^ (v[0] ? GALOIS_TAPS : 32'd0);
	endfunction

	// returns the read data and updates the shadows like the target does
	function automatic logic [31:0] ref_access(input logic we, input logic [3:0] sel,
		input logic [31:0] adr, input logic [31:0] wdat);
		logic [31:0] rd;
		rd = 32'd0;
		if (adr[31:20] == 12'h001) begin
			if (we) begin
				for (int b = 0; b < 4; b++)
					if (sel[b])
						shadow_scr[adr[13:2]][b*8 +: 8] = wdat[b*8 +: 8];
			end else
				rd = shadow_scr[adr[13:2]];
		end else if (adr[31:16] == 16'hFD05) begin
			if (we)
				shadow_sema[adr[9:2]] = wdat[7:0];
			else begin
				rd = {24'd0, shadow_sema[adr[9:2]]};
				if (shadow_sema[adr[9:2]] != 8'd0)
					shadow_sema[adr[9:2]] = shadow_sema[adr[9:2]] - 8'd1;
			end
		end else if (adr[31:8] == 24'hFD0FFF) begin
			if (we)
				shadow_led = wdat[7:0];
			else
				rd = {24'd0, shadow_led};
		end else if (adr[31:8] == 24'hFD0FFD) begin
			if (we) begin
				if (wdat != 32'd0)
					shadow_lfsr = wdat;
			end else begin
				rd = shadow_lfsr;
				shadow_lfsr = lfsr_step(shadow_lfsr);
			end
		end
		return rd;	// unmapped gives zero
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ----------------------------------------------------------
	// bus master
	// ----------------------------------------------------------
	task automatic bus_cycle(input logic we, input logic [3:0] sel, input logic [31:0] adr,
		input logic [31:0] wdat, input int hold);
		int edges;
		int acks;
		exp_q.push_back(ref_access(we, sel, adr, wdat));
		@(posedge node_clk);
		cyc_i <= 1'b1;
		stb_i <= 1'b1;
		we_i <= we;
		sel_i <= sel;
		adr_i <= adr;
		dat_i <= wdat;
		edges = 0;
		acks = 0;
		while (acks == 0 && edges < ACK_TIMEOUT) begin
			@(posedge node_clk);
			edges++;
			if (ack_o)
				acks++;
		end
		if (acks == 0) begin
			timeouts++;
			void'(exp_q.pop_back());
			$display("timeout: address %h was never acknowledged", adr);
		end else
			check_value("ack edge", edges, ACK_EDGE);
		repeat (hold) begin	// strobe held past the ack
			@(posedge node_clk);
			if (ack_o)
				acks++;
		end
		cyc_i <= 1'b0;
		stb_i <= 1'b0;
		repeat (3) begin
			@(posedge node_clk);
			if (ack_o)
				acks++;
		end
		if (acks != 0)
			check_value("ack count", acks, 1);
	endtask

	task automatic write_word(input logic [31:0] adr, input logic [3:0] sel,
		input logic [31:0] wdat, input int hold);
		bus_cycle(1'b1, sel, adr, wdat, hold);
	endtask

	task automatic read_word(input logic [31:0] adr, input int hold);
		bus_cycle(1'b0, 4'hF, adr, 32'd0, hold);
	endtask

	// checks every ack against the model and idle data against zero
	always @(posedge node_clk) begin
		logic [31:0] exp_val;
		if (!rst && ack_o === 1'b1) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("acknowledge seen with no access pending at %0t ns", $time);
			end else begin
				exp_val = exp_q.pop_front();
				check_value("read data", dat_o, exp_val);
			end
		end else if (!rst) begin
			check_value("idle data", dat_o, 32'd0);
		end
	end

	// ----------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------
	initial begin
		logic [31:0] scr_adr [8];
		logic [31:0] r;
		rst <= 1'b1;
		cyc_i <= 1'b0;
		stb_i <= 1'b0;
		we_i <= 1'b0;
		sel_i <= 4'h0;
		adr_i <= 32'd0;
		dat_i <= 32'd0;
		for (int i = 0; i < 256; i++)
			shadow_sema[i] = 8'd0;
		shadow_led = 8'd0;
		shadow_lfsr = GEN_RESET;
		repeat (2) @(posedge node_clk);
		rst <= 1'b0;
		repeat (5) @(posedge node_clk);	// idle cycles where a stray ack is caught
		check_value("led after reset", {24'd0, led_o}, 32'd0);
		read_word(RAND_ADR, 0);

		// full scratch words first so every byte is known
		for (int i = 0; i < 8; i++) begin
			r = next_rand();
			scr_adr[i] = {12'h001, 6'd0, r[13:2], 2'b00};
			write_word(scr_adr[i], 4'hF, next_rand(), 0);
		end
		for (int i = 0; i < 8; i++) begin
			r = next_rand();
			write_word(scr_adr[i], r[3:0], next_rand(), i % 2);
		end
		for (int i = 0; i < 8; i++)
			read_word(scr_adr[i], i % 3);

		// semaphores count down to zero and stay
		write_word(32'hFD05_0040, 4'h1, 32'd3, 0);
		repeat (5) read_word(32'hFD05_0040, 0);
		r = next_rand();
		write_word({16'hFD05, 6'd0, r[7:0], 2'b00}, 4'hF, 32'd2, 0);
		read_word({16'hFD05, 6'd0, r[7:0], 2'b00}, 6);	// long hold decrements once
		read_word({16'hFD05, 6'd0, r[7:0], 2'b00}, 0);

		// led and generator
		write_word(32'hFD0F_FF00, 4'h1, next_rand(), 0);
		check_value("led output", {24'd0, led_o}, {24'd0, shadow_led});
		read_word(32'hFD0F_FF00, 0);
		repeat (4) read_word(RAND_ADR, 0);
		write_word(RAND_ADR, 4'hF, next_rand() | 32'd1, 0);
		repeat (3) read_word(RAND_ADR, 1);
		write_word(RAND_ADR, 4'hF, 32'd0, 0);	// ignored
		repeat (2) read_word(RAND_ADR, 0);

		// unmapped
		read_word(32'hFD0F_FC00, 0);
		write_word(32'h0200_0000, 4'hF, next_rand(), 0);
		read_word(32'h0200_0010, 2);

		repeat (4) @(posedge node_clk);
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d accesses were never answered", exp_q.size());
		end
		$display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/io_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module io_subsys (
	input wire node_clk,
	input wire rst,
	input wire cyc_i,
	input wire stb_i,
	input wire we_i,
	input wire [io_pkg::SEL_W-1:0] sel_i,
	input wire [io_pkg::ADDR_W-1:0] adr_i,
	input wire [io_pkg::DATA_W-1:0] dat_i,
	output logic [io_pkg::DATA_W-1:0] dat_o,
	output logic ack_o,
	output logic [7:0] led_o
);

	// one link per target
	io_dev_if scr_bus ();
	io_dev_if sema_bus ();
	io_dev_if brd_bus ();

	// ----------------------------------------------------------
	// decoder
	// ----------------------------------------------------------
	io_decode io_decode_i (
		.node_clk(node_clk),
		.rst(rst),
		.cyc_i(cyc_i),
		.stb_i(stb_i),
		.we_i(we_i),
		.sel_i(sel_i),
		.adr_i(adr_i),
		.dat_i(dat_i),
		.dat_o(dat_o),
		.ack_o(ack_o),
		.scr(scr_bus),
		.sema(sema_bus),
		.brd(brd_bus)
	);

	// ----------------------------------------------------------
	// targets
	// ----------------------------------------------------------
	scratch_ram scratch_ram_i (
		.node_clk(node_clk),
		.bus(scr_bus)
	);

	sema_ram sema_ram_i (
		.node_clk(node_clk),
		.rst(rst),
		.bus(sema_bus)
	);

	board_regs board_regs_i (
		.node_clk(node_clk),
		.rst(rst),
		.bus(brd_bus),
		.led_o(led_o)	// straight to the board leds
	);

endmodule

`default_nettype wire

// File: src/board_regs.sv
`timescale 1ns/100ps
`default_nettype none

module board_regs (
	input wire node_clk,
	input wire rst,
	io_dev_if.dev bus,
	output logic [7:0] led_o
);

	logic is_led;
	logic is_rand;
	logic [31:0] lfsr;
	logic [31:0] lfsr_next;

	assign is_led = bus.adr.p24.page == io_pkg::LED_PAGE;
	assign is_rand = bus.adr.p24.page == io_pkg::RAND_PAGE;

	// one galois step, shift right and fold taps on the old lsb
	assign lfsr_next = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? io_pkg::LFSR_TAPS : 32'd0);

	// ----------------------------------------------------------
	// led register and random number generator
	// ----------------------------------------------------------
	always_ff @(posedge node_clk) begin
		if (rst) begin
			led_o <= 8'd0;
			lfsr <= io_pkg::LFSR_SEED;
			bus.ack <= 1'b0;
			bus.rdat <= '0;
		end else begin
			bus.ack <= bus.cs;
			bus.rdat <= '0;
			if (bus.cs && is_led) begin
				if (bus.we)
					led_o <= bus.wdat[7:0];
				else
					bus.rdat <= {{(io_pkg::DATA_W-8){1'b0}}, led_o};
			end else if (bus.cs && is_rand) begin
				if (bus.we) begin
					// zero would lock the generator up
					if (bus.wdat != '0)
						lfsr <= bus.wdat;
				end else begin
					bus.rdat <= lfsr;	// value first, then advance
					lfsr <= lfsr_next;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/sema_ram.sv
`timescale 1ns/100ps
`default_nettype none

module sema_ram (
	input wire node_clk,
	input wire rst,
	io_dev_if.dev bus
);

	logic [7:0] cnt [io_pkg::SEMA_DEPTH];
	logic [$clog2(io_pkg::SEMA_DEPTH)-1:0] idx;

	assign idx = bus.adr.p16.index[$clog2(io_pkg::SEMA_DEPTH)-1:0];

	// ----------------------------------------------------------
	// counting semaphores
	// ----------------------------------------------------------
	always_ff @(posedge node_clk) begin
		if (rst) begin
			for (int i = 0; i < io_pkg::SEMA_DEPTH; i++)
				cnt[i] <= 8'd0;
			bus.ack <= 1'b0;
			bus.rdat <= '0;
		end else begin
			bus.ack <= bus.cs;
			bus.rdat <= '0;
			if (bus.cs) begin
				if (bus.we) begin
					cnt[idx] <= bus.wdat[7:0];	// load count
				end else begin
					bus.rdat <= {{(io_pkg::DATA_W-8){1'b0}}, cnt[idx]};
					// take one if available, stays at zero otherwise
					if (cnt[idx] != 8'd0)
						cnt[idx] <= cnt[idx] - 8'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/scratch_ram.sv
`timescale 1ns/100ps
`default_nettype none

module scratch_ram (
	input wire node_clk,
	io_dev_if.dev bus
);

	logic [io_pkg::DATA_W-1:0] mem [io_pkg::SCR_DEPTH];
	logic [$clog2(io_pkg::SCR_DEPTH)-1:0] word_idx;

	// byte offset bits dropped
	assign word_idx = bus.adr.rgn.offset[$clog2(io_pkg::SCR_DEPTH)+1:2];

	// ----------------------------------------------------------
	// byte lane writes
	// ----------------------------------------------------------
	always_ff @(posedge node_clk) begin
		if (bus.cs && bus.we) begin
			for (int i = 0; i < io_pkg::SEL_W; i++) begin
				if (bus.sel[i])
					mem[word_idx][i*8 +: 8] <= bus.wdat[i*8 +: 8];
			end
		end
	end

	// read port and acknowledge
	always_ff @(posedge node_clk) begin
		bus.ack <= bus.cs;
		if (bus.cs && !bus.we)
			bus.rdat <= mem[word_idx];	// old contents, whole word
		else
			bus.rdat <= '0;
	end

endmodule

`default_nettype wire

// File: src/io_decode.sv
`timescale 1ns/100ps
`default_nettype none

module io_decode (
	input wire node_clk,
	input wire rst,
	input wire cyc_i,
	input wire stb_i,
	input wire we_i,
	input wire [io_pkg::SEL_W-1:0] sel_i,
	input wire [io_pkg::ADDR_W-1:0] adr_i,
	input wire [io_pkg::DATA_W-1:0] dat_i,
	output logic [io_pkg::DATA_W-1:0] dat_o,
	output logic ack_o,
	io_dev_if.ctrl scr,
	io_dev_if.ctrl sema,
	io_dev_if.ctrl brd
);

	io_pkg::io_addr_u adr_v;
	logic hit_scr;
	logic hit_sema;
	logic hit_brd;
	logic hit_any;
	logic start;
	logic busy;
	logic miss_d1;
	logic miss_d2;

	logic req_we;
	logic [io_pkg::SEL_W-1:0] req_sel;
	io_pkg::io_addr_u req_adr;
	logic [io_pkg::DATA_W-1:0] req_wdat;

	// ----------------------------------------------------------
	// address decode
	// ----------------------------------------------------------
	assign adr_v = adr_i;
	assign hit_scr = adr_v.rgn.region == io_pkg::SCR_REGION;
	assign hit_sema = adr_v.p16.page == io_pkg::SEMA_PAGE;
	assign hit_brd = (adr_v.p24.page == io_pkg::LED_PAGE) ||
		(adr_v.p24.page == io_pkg::RAND_PAGE);
	assign hit_any = hit_scr | hit_sema | hit_brd;

	// new strobe only, a held strobe never fires twice
	assign start = cyc_i & stb_i & ~busy;

	always_ff @(posedge node_clk) begin
		if (rst) begin
			busy <= 1'b0;
			scr.cs <= 1'b0;
			sema.cs <= 1'b0;
			brd.cs <= 1'b0;
			miss_d1 <= 1'b0;
			miss_d2 <= 1'b0;
		end else begin
			busy <= stb_i & (busy | start);	// drops once stb_i is seen low
			scr.cs <= start & hit_scr;
			sema.cs <= start & hit_sema;
			brd.cs <= start & hit_brd;
			miss_d1 <= start & ~hit_any;	// unmapped, ack it ourselves
			miss_d2 <= miss_d1;	// lines up with a target ack
		end
	end

	// request fields captured with the select
	always_ff @(posedge node_clk) begin
		if (start) begin
			req_we <= we_i;
			req_sel <= sel_i;
			req_adr <= adr_v;
			req_wdat <= dat_i;
		end
	end

	assign scr.we = req_we;
	assign scr.sel = req_sel;
	assign scr.adr = req_adr;
	assign scr.wdat = req_wdat;

	assign sema.we = req_we;
	assign sema.sel = req_sel;
	assign sema.adr = req_adr;
	assign sema.wdat = req_wdat;

	assign brd.we = req_we;
	assign brd.sel = req_sel;
	assign brd.adr = req_adr;
	assign brd.wdat = req_wdat;

	// ----------------------------------------------------------
	// response collection
	// ----------------------------------------------------------
	always_ff @(posedge node_clk) begin
		if (rst) begin
			ack_o <= 1'b0;
			dat_o <= '0;
		end else begin
			ack_o <= scr.ack | sema.ack | brd.ack | miss_d2;
			dat_o <= scr.rdat | sema.rdat | brd.rdat;	// idle targets give zero
		end
	end

endmodule

`default_nettype wire

// File: src/io_dev_if.sv
`timescale 1ns/100ps
`default_nettype none

interface io_dev_if;

	logic cs;	// one cycle per access
	logic we;
	logic [io_pkg::SEL_W-1:0] sel;
	io_pkg::io_addr_u adr;
	logic [io_pkg::DATA_W-1:0] wdat;
	logic [io_pkg::DATA_W-1:0] rdat;	// zero unless ack
	logic ack;

	// decoder side
	modport ctrl (output cs, we, sel, adr, wdat, input rdat, ack);

	// target side
	modport dev (input cs, we, sel, adr, wdat, output rdat, ack);

endinterface

`default_nettype wire

// File: src/io_pkg.sv
`default_nettype none

package io_pkg;

	// ----------------------------------------------------------
	// bus widths
	// ----------------------------------------------------------
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int SEL_W = 4;	// one select per byte lane

	// ----------------------------------------------------------
	// address map
	// ----------------------------------------------------------
	localparam logic [11:0] SCR_REGION = 12'h001;	// 0x001xxxxx
	localparam int SCR_DEPTH = 4096;	// words, 16 KB

	localparam logic [15:0] SEMA_PAGE = 16'hFD05;
	localparam int SEMA_DEPTH = 256;

	localparam logic [23:0] LED_PAGE = 24'hFD0FFF;
	localparam logic [23:0] RAND_PAGE = 24'hFD0FFD;

	// galois generator, x^32+x^22+x^2+x+1
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam logic [31:0] LFSR_SEED = 32'h0000_0001;

	// one address word seen three ways
	typedef union packed {
		struct packed {
			logic [11:0] region;
			logic [19:0] offset;
		} rgn;	// scratch decode
		struct packed {
			logic [15:0] page;
			logic [13:0] index;
			logic [1:0] byte_sel;
		} p16;	// semaphore decode
		struct packed {
			logic [23:0] page;
			logic [7:0] reg_ofs;
		} p24;	// led and random
	} io_addr_u;

endpackage

`default_nettype wire
